/* dag1Regs.f */
design/dagPkg.sv
design/isaPkg.sv
design/dagBankIf.sv
design/regBank.sv
design/dagControl.sv
design/dagRegFile.sv
design/operandLatch.sv
design/dmAddrPath.sv
design/dag1Top.sv
tests/dag1Checker.sv
tests/dag1Tb.sv

/* Makefile */
TOP = dag1Tb

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f dag1Regs.f -o dag1Sim
	@out="$$(./obj_dir/dag1Sim)"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only -Wall --timing --top-module dag1Top -f dag1Regs.f

clean:
	rm -rf obj_dir

/* tests/dag1Golden.txt */
# ctl bits: goC goE exEn post1E dag1En dmaEn mstat1 mfDag1 dag1Sel dag2Sel immSel
# ctl ir ire mtI mtL mtM mfI mfL mfM newI1 dmdIn dag2Addr | iOp lOp mOp dmaR dma dmd
# Registered columns hold the state after the edge that applies this line
00000000000 00000 0 0 0 0 f f f 0000 0000 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 1 0 0 0 0 0000 0123 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 2 0 0 0 0 0000 2a5c 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 4 0 0 0 0 0000 1fff 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 8 0 0 0 0 0000 3001 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 0 1 0 0 0 0000 0010 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 0 2 0 0 0 0000 3fff 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 0 4 0 0 0 0000 2000 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 0 0 8 0 0 0 0000 1abc 0000  0000 0000 0000 0000 0000 0000
00000001000 00000 0 0 0 0 0 1 0 0000 0000 0000  0000 0000 0000 0000 0000 0123
00000001000 00000 0 0 0 0 0 2 0 0000 0000 0000  0000 0000 0000 0000 0000 2a5c
00000001000 00000 0 0 0 0 0 4 0 0000 0000 0000  0000 0000 0000 0000 0000 1fff
00000001000 00000 0 0 0 0 0 8 0 0000 0000 0000  0000 0000 0000 0000 0000 3001
00000001000 00000 0 0 0 0 0 0 1 0000 0000 0000  0000 0000 0000 0000 0000 0010
00000001000 00000 0 0 0 0 0 0 2 0000 0000 0000  0000 0000 0000 0000 0000 ffff
00000001000 00000 0 0 0 0 0 0 4 0000 0000 0000  0000 0000 0000 0000 0000 e000
00000001000 00000 0 0 0 0 0 0 8 0000 0000 0000  0000 0000 0000 0000 0000 1abc
10110000000 00000 4 0 0 0 0 0 0 0155 0000 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 4 0 0 0 0 0 0000 2468 0000  0000 0000 0000 0000 0000 0000
10110000000 00000 c 0 0 0 0 0 0 3a00 0000 0000  0000 0000 0000 0000 0000 0000
00110000000 00000 0 0 0 0 0 0 0 1111 0000 0000  0000 0000 0000 0000 0000 0000
00000001000 00000 0 0 0 0 1 0 0 0000 0000 0000  0000 0000 0000 0000 0000 0000
10100000000 00000 0 1 0 0 0 0 0 0000 0040 0000  0000 0000 0000 0000 0000 0000
00000001000 00000 0 0 0 0 2 0 0 0000 0000 0000  0000 0000 0000 0000 0000 0155
00000001000 00000 0 0 0 0 4 0 0 0000 0000 0000  0000 0000 0000 0000 0000 2468
00000001000 00000 0 0 0 0 8 0 0 0000 0000 0000  0000 0000 0000 0000 0000 3a00
00000001000 00000 0 0 0 0 1 0 0 0000 0000 0000  0000 0000 0000 0000 0000 0040
01001000000 00006 0 0 0 0 0 0 0 0000 0000 0000  0000 0000 0000 0000 0000 0000
00000000000 00000 0 0 0 0 0 0 0 0000 0000 0000  0155 2a5c 2000 0000 0000 0000
11111000000 0000f c 0 8 8 0 0 0 0abc 1234 0000  0155 2a5c 2000 0000 0000 0000
00000000000 00000 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0000 0000 0000
00001000000 00000 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0000 0000 0000
00000000000 00000 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0000 0000 0000
01000100100 00004 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0155 0000 0000
01000110100 00008 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0589 0155 0000
01000100010 00000 0 0 0 0 0 0 0 0000 0000 2bcd  0abc 1234 1234 2bcd 0589 0000
01000100001 13570 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 1357 2bcd 0000
01000000001 3fff0 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 3fff 1357 0000
00000100100 0000c 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0abc 1357 0000
00000000000 00000 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0000 1357 0000
11100100100 00000 0 1 0 0 0 0 0 0000 0777 0000  0abc 1234 1234 0777 1357 0000
00000001000 00000 0 0 0 0 1 0 0 0000 0000 0000  0abc 1234 1234 0000 0777 0777
00000000000 00000 0 0 0 0 0 0 0 0000 0000 0000  0abc 1234 1234 0000 0777 0000

/* tests/dag1Tb.sv */
`timescale 1ns/10ps

module dag1Tb;
  import dagPkg::*;
  import isaPkg::*;

  localparam int MaxCycles = 200;

  logic    DSPCLK;
  logic    RST;
  logic    goC, goE, exEn, post1E, dag1En, dmaEn;
  logic    mstat1, mfDag1, dag1Sel, dag2Sel, immSel;
  irT      ir;
  logic    [3:0] ire;
  regMaskT mtIreg, mtLreg, mtMreg, mfIreg, mfLreg, mfMreg;
  addrT    newI1, dmdIn, dag2Addr;
  addrT    iOp, lOp, mOp, dmaR, dma;
  dmdT     dmd;

  logic    check, fileError, timedOut, runDone, reported;
  int      errors;
  addrT    expIOp, expLOp, expMOp, expDmaR, expDma;
  dmdT     expDmd;

  // Fields of one golden line
  logic [10:0] ctl;
  logic [17:0] irV;
  logic [3:0]  ireV, mtI, mtL, mtM, mfI, mfL, mfM;
  addrT        newV, dmdV, d2V, eI, eL, eM, eR, eA;
  dmdT         eD;

  dag1Top dut (.*);

  dag1Checker chk (.*);

  initial DSPCLK = 1'b0;
  always #50 DSPCLK = ~DSPCLK;

  task automatic driveVector();
    {goC, goE, exEn, post1E, dag1En, dmaEn} <= ctl[10:5];
    {mstat1, mfDag1, dag1Sel, dag2Sel, immSel} <= ctl[4:0];
    ir <= irV;
    ire <= ireV;
    {mtIreg, mtLreg, mtMreg} <= {mtI, mtL, mtM};
    // Data inputs nobody looks at get random filler
    mfIreg <= ctl[3] ? mfI : regMaskT'($urandom);
    mfLreg <= ctl[3] ? mfL : regMaskT'($urandom);
    mfMreg <= ctl[3] ? mfM : regMaskT'($urandom);
    newI1 <= ctl[7] ? newV : addrT'($urandom);
    dmdIn <= ((mtI | mtL | mtM) != 4'h0) ? dmdV : addrT'($urandom);
    dag2Addr <= ctl[1] ? d2V : addrT'($urandom);
    {expIOp, expLOp, expMOp} <= {eI, eL, eM};
    {expDmaR, expDma, expDmd} <= {eR, eA, eD};
    check <= 1'b1;
  endtask

  initial
  begin
    int    fd;
    int    fields;
    int    cycles;
    int    waitCycles;
    bit    gotVec;
    bit    eof;
    string line;

    void'($urandom(4));
    {goC, goE, exEn, post1E, dag1En, dmaEn} = '0;
    {mstat1, mfDag1, dag1Sel, dag2Sel, immSel} = '0;
    {ir, ire, mtIreg, mtLreg, mtMreg, mfIreg, mfLreg, mfMreg} = '0;
    {newI1, dmdIn, dag2Addr} = '0;
    {check, fileError, timedOut, runDone} = '0;
    {expIOp, expLOp, expMOp, expDmaR, expDma, expDmd} = '0;
    RST = 1'b1;
    repeat (2) @(posedge DSPCLK);
    RST <= 1'b0;

    fd = $fopen("tests/dag1Golden.txt", "r");
    if (fd == 0)
    begin
      fileError <= 1'b1;
    end
    eof = (fd == 0);
    cycles = 0;
    while (!eof && cycles < MaxCycles)
    begin
      @(posedge DSPCLK);
      cycles++;
      gotVec = 1'b0;
      while (!gotVec && !$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#")
        begin
          fields = $sscanf(line, "%b %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           ctl, irV, ireV, mtI, mtL, mtM, mfI, mfL, mfM, newV, dmdV, d2V,
                           eI, eL, eM, eR, eA, eD);
          if (fields == 18)
          begin
            gotVec = 1'b1;
          end
          else
          begin
            fileError <= 1'b1;
          end
        end
      end
      if (gotVec)
      begin
        driveVector();
      end
      else
      begin
        check <= 1'b0;
        eof = 1'b1;
      end
    end
    if (fd != 0)
    begin
      $fclose(fd);
    end
    if (!eof)
    begin
      check <= 1'b0;
      timedOut <= 1'b1;
    end

    // Let the checker print its counts
    runDone <= 1'b1;
    waitCycles = 0;
    while (!reported && waitCycles < 4)
    begin
      @(posedge DSPCLK);
      waitCycles++;
    end
    if (reported && errors == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tests/dag1Checker.sv */
`timescale 1ns/10ps

module dag1Checker (
  input  logic         DSPCLK,
  input  logic         check,     // Expected values valid this cycle
  input  logic         fileError,
  input  logic         timedOut,
  input  logic         runDone,
  input  dagPkg::addrT expIOp,
  input  dagPkg::addrT expLOp,
  input  dagPkg::addrT expMOp,
  input  dagPkg::addrT expDmaR,
  input  dagPkg::addrT expDma,
  input  dagPkg::dmdT  expDmd,
  input  dagPkg::addrT iOp,
  input  dagPkg::addrT lOp,
  input  dagPkg::addrT mOp,
  input  dagPkg::addrT dmaR,
  input  dagPkg::addrT dma,
  input  dagPkg::dmdT  dmd,
  output int           errors,
  output logic         reported
);
  int   checks = 0;
  int   mismatches = 0;
  int   otherErrs = 0;
  logic fileNoted = 1'b0;
  logic timeoutNoted = 1'b0;

  task automatic compare(input string name, input logic [15:0] expVal,
                         input logic [15:0] actVal);
    checks++;
    if (actVal !== expVal)
    begin
      mismatches++;
      $display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, name, expVal, actVal);
    end
  endtask

  initial
  begin
    errors = 0;
    reported = 1'b0;
  end

  // Outputs settled half a period after the inputs changed
  always @(negedge DSPCLK)
  begin
    if (check)
    begin
      compare("iOp", 16'(expIOp), 16'(iOp));
      compare("lOp", 16'(expLOp), 16'(lOp));
      compare("mOp", 16'(expMOp), 16'(mOp));
      compare("dmaR", 16'(expDmaR), 16'(dmaR));
      compare("dma", 16'(expDma), 16'(dma));
      compare("dmd", expDmd, dmd);
    end
    if (fileError && !fileNoted)
    begin
      $display("Golden file tests/dag1Golden.txt is missing or holds a malformed line");
      fileNoted = 1'b1;
      otherErrs++;
    end
    if (timedOut && !timeoutNoted)
    begin
      $display("Golden vectors did not finish within the cycle limit");
      timeoutNoted = 1'b1;
      otherErrs++;
    end
    errors = mismatches + otherErrs;
    if (runDone && !reported)
    begin
      $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, otherErrs);
      reported = 1'b1;
    end
  end

endmodule

/* design/dag1Top.sv */
`timescale 1ns/10ps

module dag1Top (
  input  logic            DSPCLK,
  input  logic            RST,
  input  logic            goC,
  input  logic            goE,
  input  logic            exEn,
  input  logic            post1E,
  input  logic            dag1En,
  input  logic            dmaEn,
  input  logic            mstat1,
  input  logic            mfDag1,
  input  logic            dag1Sel,
  input  logic            dag2Sel,
  input  logic            immSel,
  input  isaPkg::irT      ir,
  input  logic [3:0]      ire,
  input  dagPkg::regMaskT mtIreg,
  input  dagPkg::regMaskT mtLreg,
  input  dagPkg::regMaskT mtMreg,
  input  dagPkg::regMaskT mfIreg,
  input  dagPkg::regMaskT mfLreg,
  input  dagPkg::regMaskT mfMreg,
  input  dagPkg::addrT    newI1,
  input  dagPkg::addrT    dmdIn,
  input  dagPkg::addrT    dag2Addr,
  output dagPkg::addrT    iOp,
  output dagPkg::addrT    lOp,
  output dagPkg::addrT    mOp,
  output dagPkg::addrT    dmaR,
  output dagPkg::addrT    dma,
  output dagPkg::dmdT     dmd
);

  dagBankIf iBank ();
  dagBankIf lBank ();
  dagBankIf mBank ();

  dagControl uCtrl (
    .goC    (goC),
    .exEn   (exEn),
    .post1E (post1E),
    .mtIreg (mtIreg),
    .mtLreg (mtLreg),
    .mtMreg (mtMreg),
    .mfIreg (mfIreg),
    .mfLreg (mfLreg),
    .mfMreg (mfMreg),
    .ire    (ire),
    .ir     (ir),
    .newI1  (newI1),
    .dmdIn  (dmdIn),
    .iBank  (iBank.ctrl),
    .lBank  (lBank.ctrl),
    .mBank  (mBank.ctrl)
  );

  dagRegFile uRegFile (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .mfDag1 (mfDag1),
    .iBank  (iBank.bank),
    .lBank  (lBank.bank),
    .mBank  (mBank.bank),
    .dmd    (dmd)
  );

  operandLatch uOpLatch (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .goE    (goE),
    .dag1En (dag1En),
    .iD     (iBank.rdOperand),
    .lD     (lBank.rdOperand),
    .mD     (mBank.rdOperand),
    .iOp    (iOp),
    .lOp    (lOp),
    .mOp    (mOp)
  );

  // Address taken from the bypassed I operand, ahead of the latch
  dmAddrPath uAddrPath (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .goE      (goE),
    .dmaEn    (dmaEn),
    .mstat1   (mstat1),
    .dag1Sel  (dag1Sel),
    .dag2Sel  (dag2Sel),
    .immSel   (immSel),
    .iD       (iBank.rdOperand),
    .dag2Addr (dag2Addr),
    .ir       (ir),
    .dmaR     (dmaR),
    .dma      (dma)
  );

endmodule

/* design/dmAddrPath.sv */
`timescale 1ns/10ps

module dmAddrPath (
  input  logic         DSPCLK,
  input  logic         RST,
  input  logic         goE,
  input  logic         dmaEn,
  input  logic         mstat1,
  input  logic         dag1Sel,
  input  logic         dag2Sel,
  input  logic         immSel,
  input  dagPkg::addrT iD,
  input  dagPkg::addrT dag2Addr,
  input  isaPkg::irT   ir,
  output dagPkg::addrT dmaR,
  output dagPkg::addrT dma
);
  import dagPkg::*;
  import isaPkg::*;

  addrT revI;
  addrT dag1Addr;
  addrT immAddr;

  // Bit-reversed addressing for FFT buffers
  always_comb
  begin
    for (int b = 0; b < AddrW; b++)
    begin
      revI[b] = iD[AddrW-1-b];
    end
  end

  assign dag1Addr = mstat1 ? revI : iD;
  assign immAddr = ir[ImmLo +: AddrW];

  // Selects are exclusive from the decoder
  assign dmaR = ({AddrW{dag1Sel}} & dag1Addr)
              | ({AddrW{dag2Sel}} & dag2Addr)
              | ({AddrW{immSel}} & immAddr);

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      dma <= '0;
    end
    else if (goE && dmaEn)
    begin
      dma <= dmaR;
    end
  end

endmodule

/* design/operandLatch.sv */
`timescale 1ns/10ps

module operandLatch (
  input  logic         DSPCLK,
  input  logic         RST,
  input  logic         goE,
  input  logic         dag1En,
  input  dagPkg::addrT iD,
  input  dagPkg::addrT lD,
  input  dagPkg::addrT mD,
  output dagPkg::addrT iOp,
  output dagPkg::addrT lOp,
  output dagPkg::addrT mOp
);
  import dagPkg::*;

  logic capture;

  assign capture = goE & dag1En;

  // Operands for the post-modify adder in the next stage
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      iOp <= '0;
      lOp <= '0;
      mOp <= '0;
    end
    else if (capture)
    begin
      iOp <= iD;
      lOp <= lD;
      mOp <= mD;
    end
  end

endmodule

/* design/dagRegFile.sv */
`timescale 1ns/10ps

module dagRegFile (
  input  logic        DSPCLK,
  input  logic        RST,
  input  logic        mfDag1,
  dagBankIf.bank      iBank,
  dagBankIf.bank      lBank,
  dagBankIf.bank      mBank,
  output dagPkg::dmdT dmd
);
  import dagPkg::*;

  addrT mergedData;
  dmdT  busWord;

  regBank iRegs (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .bus    (iBank)
  );

  regBank lRegs (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .bus    (lBank)
  );

  regBank mRegs (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .bus    (mBank)
  );

  // Only one bank is read back at a time
  assign mergedData = iBank.mfData | lBank.mfData | mBank.mfData;

  // Modify values are signed, so the top bits copy the M sign
  assign busWord = {{(DmdW - AddrW){mBank.mfData[AddrW-1]}}, mergedData};

  assign dmd = {DmdW{mfDag1}} & busWord;  // Off the bus unless selected

endmodule

/* design/dagControl.sv */
`timescale 1ns/10ps

module dagControl (
  input  logic            goC,
  input  logic            exEn,
  input  logic            post1E,
  input  dagPkg::regMaskT mtIreg,
  input  dagPkg::regMaskT mtLreg,
  input  dagPkg::regMaskT mtMreg,
  input  dagPkg::regMaskT mfIreg,
  input  dagPkg::regMaskT mfLreg,
  input  dagPkg::regMaskT mfMreg,
  input  logic [3:0]      ire,
  input  isaPkg::irT      ir,
  input  dagPkg::addrT    newI1,
  input  dagPkg::addrT    dmdIn,
  dagBankIf.ctrl          iBank,
  dagBankIf.ctrl          lBank,
  dagBankIf.ctrl          mBank
);
  import dagPkg::*;
  import isaPkg::*;

  logic    wrGate;
  regSelT  postSel;
  regMaskT postLd;

  assign wrGate = exEn & goC;  // Execute in the C phase
  assign postSel = ire[3:2];   // I register of the executing instruction

  // Post-modify decode
  always_comb
  begin
    postLd = '0;
    postLd[postSel] = post1E;
  end

  assign iBank.ld = {NumRegs{wrGate}} & (mtIreg | postLd);
  assign lBank.ld = {NumRegs{wrGate}} & mtLreg;
  assign mBank.ld = {NumRegs{wrGate}} & mtMreg;

  // Updated index takes the I write port during post-modify
  assign iBank.wrData = post1E ? newI1 : dmdIn;
  assign lBank.wrData = dmdIn;
  assign mBank.wrData = dmdIn;

  // L follows the I field
  assign iBank.rdSel = ir[IFieldLo +: $bits(regSelT)];
  assign lBank.rdSel = ir[IFieldLo +: $bits(regSelT)];
  assign mBank.rdSel = ir[MFieldLo +: $bits(regSelT)];

  assign iBank.mfSel = mfIreg;
  assign lBank.mfSel = mfLreg;
  assign mBank.mfSel = mfMreg;

endmodule

/* design/regBank.sv */
`timescale 1ns/10ps

module regBank (
  input logic    DSPCLK,
  input logic    RST,
  dagBankIf.bank bus
);
  import dagPkg::*;

  addrT entry [NumRegs];
  addrT readback;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      for (int k = 0; k < NumRegs; k++)
      begin
        entry[k] <= '0;
      end
    end
    else
    begin
      for (int k = 0; k < NumRegs; k++)
      begin
        if (bus.ld[k])
        begin
          entry[k] <= bus.wrData;
        end
      end
    end
  end

  // Write in the same cycle wins over the stored entry
  assign bus.rdOperand = bus.ld[bus.rdSel] ? bus.wrData : entry[bus.rdSel];

  // Wired-OR readback, normally a single bit set
  always_comb
  begin
    readback = '0;
    for (int k = 0; k < NumRegs; k++)
    begin
      if (bus.mfSel[k])
      begin
        readback = readback | entry[k];
      end
    end
  end

  assign bus.mfData = readback;

endmodule

/* design/dagBankIf.sv */
`timescale 1ns/10ps

interface dagBankIf;
  import dagPkg::*;

  regMaskT ld;         // Per-entry load strobe
  addrT    wrData;
  regSelT  rdSel;      // Operand entry
  addrT    rdOperand;  // Entry or bypassed write data
  regMaskT mfSel;      // One-hot readback
  addrT    mfData;

  // Decode side
  modport ctrl (
    output ld,
    output wrData,
    output rdSel,
    output mfSel,
    input  rdOperand,
    input  mfData
  );

  // Storage side
  modport bank (
    input  ld,
    input  wrData,
    input  rdSel,
    input  mfSel,
    output rdOperand,
    output mfData
  );

endinterface

/* design/isaPkg.sv */
package isaPkg;

  localparam int IrW = 18;

  // Register select fields of the address generator instructions
  localparam int IFieldLo = 2;   // ir[3:2], shared by I and L
  localparam int MFieldLo = 0;   // ir[1:0]

  // Direct addressing carries the address in the upper bits
  localparam int ImmLo = 4;      // ir[17:4]

  typedef logic [IrW-1:0] irT;

endpackage

/* design/dagPkg.sv */
package dagPkg;

  // Datapath widths of the first address generator
  localparam int AddrW = 14;
  localparam int DmdW = 16;    // Data memory bus
  localparam int NumRegs = 4;  // Entries per bank

  // One index, length or modify value
  typedef logic [AddrW-1:0] addrT;

  typedef logic [DmdW-1:0] dmdT;

  // Entry number within a bank
  typedef logic [$clog2(NumRegs)-1:0] regSelT;

  // One bit per entry
  typedef logic [NumRegs-1:0] regMaskT;

endpackage
